//--- design/cpuPkg.sv
package cpuPkg;

	typedef logic [31:0] wordT;
	typedef logic [4:0]  regAddrT;
	typedef logic [1:0]  stageTimeT; // tUse / tNew in stages

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluSltu, aluAndi, aluOri, aluLui
	} aluOpT;

	localparam logic [5:0] opSpecial = 6'h00;
	localparam logic [5:0] opAddi    = 6'h08;
	localparam logic [5:0] opAndi    = 6'h0c;
	localparam logic [5:0] opOri     = 6'h0d;
	localparam logic [5:0] opLui     = 6'h0f;
	localparam logic [5:0] opLw      = 6'h23;
	localparam logic [5:0] opSw      = 6'h2b;
	localparam logic [5:0] opBeq     = 6'h04;
	localparam logic [5:0] opBne     = 6'h05;
	localparam logic [5:0] opJal     = 6'h03;

	localparam logic [5:0] fnAdd  = 6'h20;
	localparam logic [5:0] fnSub  = 6'h22;
	localparam logic [5:0] fnAnd  = 6'h24;
	localparam logic [5:0] fnOr   = 6'h25;
	localparam logic [5:0] fnSlt  = 6'h2a;
	localparam logic [5:0] fnSltu = 6'h2b;

	localparam regAddrT regRa = 5'd31; // jal link

	typedef struct packed {
		aluOpT     aluOp;
		logic      immSel;  // b comes from the immediate
		logic      immZext;
		logic      memRead;
		logic      memWrite;
		logic      isBranch;
		logic      branchOnNotEqual;
		logic      isJal;
		logic      regWrite;
		regAddrT   dest;    // Zero when nothing is written
		stageTimeT tNew;
	} ctrlT;

	typedef struct packed {
		regAddrT   dest;
		stageTimeT tNew;
		wordT      value;
	} fwdSrcT;

	typedef struct packed {
		wordT        pc;
		ctrlT        ctrl;
		regAddrT     rs;
		regAddrT     rt;
		wordT        rsVal;
		wordT        rtVal;
		logic [15:0] imm;
	} idExT;

	typedef struct packed {
		wordT    pc;
		ctrlT    ctrl;
		regAddrT rt;
		wordT    storeVal;
		wordT    result;
	} exMemT;

	typedef struct packed {
		wordT pc;
		ctrlT ctrl;
		wordT value;
	} memWbT;

	// One stage closer to the result, saturating at zero
	function automatic stageTimeT ageTime(stageTimeT t);
		return (t != 2'd0) ? t - 2'd1 : 2'd0;
	endfunction

endpackage

//--- design/regFile.sv
`timescale 1ns/1ps
module regFile import cpuPkg::*; (
	input  logic    clk,
	input  logic    rstN,
	input  regAddrT rsAddr,
	input  regAddrT rtAddr,
	output wordT    rsData,
	output wordT    rtData,
	input  logic    we,
	input  regAddrT wAddr,
	input  wordT    wData
);

	wordT regs [32];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wAddr != '0) begin
			regs[wAddr] <= wData;
		end
	end

	// Writeback value bypasses the array in the same cycle
	assign rsData = (we && wAddr != '0 && wAddr == rsAddr) ? wData : regs[rsAddr];
	assign rtData = (we && wAddr != '0 && wAddr == rtAddr) ? wData : regs[rtAddr];

	zeroReg: assert property (@(posedge clk) disable iff (!rstN)
		(rsAddr != '0 || rsData == '0) && (rtAddr != '0 || rtData == '0));

endmodule

//--- design/alu.sv
`timescale 1ns/1ps
module alu import cpuPkg::*; (
	input  wordT  a,
	input  wordT  b,
	input  aluOpT op,
	output wordT  result
);

	wordT immZ;

	assign immZ = {16'h0000, b[15:0]};

	always_comb begin
		case (op)
			aluAdd:  result = a + b; // Wraps, no overflow trap
			aluSub:  result = a - b;
			aluAnd:  result = a & b;
			aluOr:   result = a | b;
			aluSlt: begin
				result = {31'b0, $signed(a) < $signed(b)};
			end
			aluSltu: begin
				result = {31'b0, a < b};
			end
			aluAndi: result = a & immZ;
			aluOri:  result = a | immZ;
			aluLui:  result = {b[15:0], 16'h0000};
			default: result = '0;
		endcase
	end

endmodule

//--- design/decoder.sv
`timescale 1ns/1ps
module decoder import cpuPkg::*; (
	input  wordT      instr,
	output ctrlT      ctrl,
	output logic      rsUsed,
	output logic      rtUsed,
	output stageTimeT rsUse,
	output stageTimeT rtUse
);

	logic [5:0] op;
	logic [5:0] funct;
	regAddrT    rt;
	regAddrT    rd;

	assign op    = instr[31:26];
	assign funct = instr[5:0];
	assign rt    = instr[20:16];
	assign rd    = instr[15:11];

	always_comb begin
		ctrl   = '0; // Anything unknown is a no-op
		rsUsed = 1'b0;
		rtUsed = 1'b0;
		rsUse  = 2'd0;
		rtUse  = 2'd0;
		case (op)
			opSpecial: begin
				if (funct inside {fnAdd, fnSub, fnAnd, fnOr, fnSlt, fnSltu}) begin
					case (funct)
						fnSub:   ctrl.aluOp = aluSub;
						fnAnd:   ctrl.aluOp = aluAnd;
						fnOr:    ctrl.aluOp = aluOr;
						fnSlt:   ctrl.aluOp = aluSlt;
						fnSltu:  ctrl.aluOp = aluSltu;
						default: ctrl.aluOp = aluAdd;
					endcase
					ctrl.regWrite = 1'b1;
					ctrl.dest     = rd;
					ctrl.tNew     = 2'd1;
					rsUsed        = 1'b1;
					rtUsed        = 1'b1;
					rsUse         = 2'd1;
					rtUse         = 2'd1;
				end
			end
			opAddi, opAndi, opOri, opLw: begin
				ctrl.aluOp    = (op == opAndi) ? aluAndi : (op == opOri) ? aluOri : aluAdd;
				ctrl.immSel   = 1'b1;
				ctrl.immZext  = op inside {opAndi, opOri};
				ctrl.memRead  = (op == opLw);
				ctrl.regWrite = 1'b1;
				ctrl.dest     = rt;
				ctrl.tNew     = (op == opLw) ? 2'd2 : 2'd1; // Load data arrives a stage later
				rsUsed        = 1'b1;
				rsUse         = 2'd1;
			end
			opLui: begin
				ctrl.aluOp    = aluLui;
				ctrl.immSel   = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.dest     = rt;
			end
			opSw: begin
				ctrl.immSel   = 1'b1;
				ctrl.memWrite = 1'b1;
				rsUsed        = 1'b1;
				rtUsed        = 1'b1;
				rsUse         = 2'd1;
				rtUse         = 2'd2; // Needed only in memory stage
			end
			opBeq, opBne: begin
				ctrl.isBranch         = 1'b1;
				ctrl.branchOnNotEqual = (op == opBne);
				rsUsed                = 1'b1;
				rtUsed                = 1'b1;
			end
			opJal: begin
				ctrl.isJal    = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.dest     = regRa;
			end
			default: ctrl = '0;
		endcase
	end

endmodule

//--- design/hazardUnit.sv
`timescale 1ns/1ps
module hazardUnit import cpuPkg::*; (
	input  regAddrT   rsAddrD,
	input  regAddrT   rtAddrD,
	input  logic      rsUsed,
	input  logic      rtUsed,
	input  stageTimeT rsUse,
	input  stageTimeT rtUse,
	input  wordT      rsFileD,
	input  wordT      rtFileD,
	input  regAddrT   rsAddrE,
	input  regAddrT   rtAddrE,
	input  wordT      rsRegE,
	input  wordT      rtRegE,
	input  fwdSrcT    srcE,
	input  fwdSrcT    srcM,
	input  fwdSrcT    srcW,
	output logic      stall,
	output wordT      rsD,
	output wordT      rtD,
	output wordT      rsE,
	output wordT      rtE
);

	localparam fwdSrcT noSrc = '0;

	fwdSrcT rsNearD, rtNearD;
	fwdSrcT rsNearE, rtNearE;
	logic   rsStall, rtStall;

	// Youngest in-flight record writing addr
	function automatic fwdSrcT nearest(regAddrT addr, fwdSrcT young, fwdSrcT mid, fwdSrcT old);
		if (addr == '0)
			return noSrc;
		if (addr == young.dest)
			return young;
		if (addr == mid.dest)
			return mid;
		if (addr == old.dest)
			return old;
		return noSrc;
	endfunction

	function automatic wordT pick(fwdSrcT near, wordT base);
		return (near.dest != '0 && near.tNew == 2'd0) ? near.value : base;
	endfunction

	////////////////////////////////////////////////////////////
	// Decode operands

	assign rsNearD = nearest(rsAddrD, srcE, srcM, srcW);
	assign rtNearD = nearest(rtAddrD, srcE, srcM, srcW);
	assign rsStall = rsUsed && rsNearD.dest != '0 && rsUse < rsNearD.tNew;
	assign rtStall = rtUsed && rtNearD.dest != '0 && rtUse < rtNearD.tNew;
	assign stall   = rsStall || rtStall;
	assign rsD     = pick(rsNearD, rsFileD);
	assign rtD     = pick(rtNearD, rtFileD);

	////////////////////////////////////////////////////////////
	// Execute operands

	assign rsNearE = nearest(rsAddrE, srcM, srcW, noSrc);
	assign rtNearE = nearest(rtAddrE, srcM, srcW, noSrc);
	assign rsE     = pick(rsNearE, rsRegE);
	assign rtE     = pick(rtNearE, rtRegE);

	// A stall waits on a real register still pending in execute or memory
	always_comb begin
		stallCause: assert final (!stall
			|| (rsUsed && rsAddrD != '0
				&& ((rsAddrD == srcE.dest && srcE.tNew != 2'd0)
				|| (rsAddrD == srcM.dest && srcM.tNew != 2'd0)))
			|| (rtUsed && rtAddrD != '0
				&& ((rtAddrD == srcE.dest && srcE.tNew != 2'd0)
				|| (rtAddrD == srcM.dest && srcM.tNew != 2'd0))));
	end

endmodule

//--- design/cpuCore.sv
`timescale 1ns/1ps
module cpuCore import cpuPkg::*; #(
	parameter wordT resetPc = 32'h0000_3000
) (
	input  logic    clk,
	input  logic    rstN,
	output wordT    instAddr,
	input  wordT    instData,
	output wordT    dataAddr,
	output wordT    dataWdata,
	output logic    dataWe,
	input  wordT    dataRdata,
	output logic    grfWe,
	output regAddrT grfAddr,
	output wordT    grfWdata,
	output wordT    wbPc
);

	wordT      pcF, npc;
	wordT      ifIdPc, ifIdInstr;
	idExT      idEx;
	exMemT     exMem;
	memWbT     memWb;
	ctrlT      ctrlD;
	logic      rsUsed, rtUsed, stall, taken;
	stageTimeT rsUse, rtUse;
	regAddrT   rsAddrD, rtAddrD;
	wordT      rsFile, rtFile, rsD, rtD, rsE, rtE;
	wordT      branchOff, immE, aluB, aluRes;
	fwdSrcT    srcE, srcM, srcW;

	////////////////////////////////////////////////////////////
	// Fetch

	assign instAddr = pcF;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pcF       <= resetPc;
			ifIdInstr <= '0; // Decodes as a no-op
		end else if (!stall) begin
			pcF       <= npc;
			ifIdPc    <= pcF;
			ifIdInstr <= instData;
		end
	end

	////////////////////////////////////////////////////////////
	// Decode and branch resolution

	assign rsAddrD   = ifIdInstr[25:21];
	assign rtAddrD   = ifIdInstr[20:16];
	assign branchOff = {{14{ifIdInstr[15]}}, ifIdInstr[15:0], 2'b00};

	decoder decoder_i (.instr(ifIdInstr), .ctrl(ctrlD), .rsUsed(rsUsed), .rtUsed(rtUsed),
		.rsUse(rsUse), .rtUse(rtUse));

	regFile regFile_i (.clk(clk), .rstN(rstN), .rsAddr(rsAddrD), .rtAddr(rtAddrD),
		.rsData(rsFile), .rtData(rtFile), .we(memWb.ctrl.regWrite),
		.wAddr(memWb.ctrl.dest), .wData(memWb.value));

	assign srcE = '{dest: idEx.ctrl.dest, tNew: idEx.ctrl.tNew,
		value: idEx.ctrl.isJal ? idEx.pc + 32'd8 : {idEx.imm, 16'h0000}};
	assign srcM = '{dest: exMem.ctrl.dest, tNew: exMem.ctrl.tNew, value: exMem.result};
	assign srcW = '{dest: memWb.ctrl.dest, tNew: memWb.ctrl.tNew, value: memWb.value};

	hazardUnit hazardUnit_i (.rsAddrD(rsAddrD), .rtAddrD(rtAddrD), .rsUsed(rsUsed),
		.rtUsed(rtUsed), .rsUse(rsUse), .rtUse(rtUse), .rsFileD(rsFile), .rtFileD(rtFile),
		.rsAddrE(idEx.rs), .rtAddrE(idEx.rt), .rsRegE(idEx.rsVal), .rtRegE(idEx.rtVal),
		.srcE(srcE), .srcM(srcM), .srcW(srcW), .stall(stall),
		.rsD(rsD), .rtD(rtD), .rsE(rsE), .rtE(rtE));

	// pcF already holds the delay slot
	always_comb begin
		taken = ctrlD.isBranch && ((rsD == rtD) != ctrlD.branchOnNotEqual);
		if (ctrlD.isJal)
			npc = {pcF[31:28], ifIdInstr[25:0], 2'b00};
		else if (taken)
			npc = pcF + branchOff;
		else
			npc = pcF + 32'd4;
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			idEx.ctrl <= '0;
		end else begin
			idEx <= '{pc: ifIdPc, ctrl: ctrlD, rs: rsAddrD, rt: rtAddrD,
				rsVal: rsD, rtVal: rtD, imm: ifIdInstr[15:0]};
			if (stall)
				idEx.ctrl <= '0; // Bubble
		end
	end

	////////////////////////////////////////////////////////////
	// Execute

	assign immE = idEx.ctrl.immZext ? {16'h0000, idEx.imm} : {{16{idEx.imm[15]}}, idEx.imm};
	assign aluB = idEx.ctrl.immSel ? immE : rtE;

	alu alu_i (.a(rsE), .b(aluB), .op(idEx.ctrl.aluOp), .result(aluRes));

	always_ff @(posedge clk) begin
		if (!rstN) begin
			exMem.ctrl <= '0;
		end else begin
			exMem.pc        <= idEx.pc;
			exMem.ctrl      <= idEx.ctrl;
			exMem.ctrl.tNew <= ageTime(idEx.ctrl.tNew);
			exMem.rt        <= idEx.rt;
			exMem.storeVal  <= rtE;
			exMem.result    <= idEx.ctrl.isJal ? idEx.pc + 32'd8 : aluRes; // Link value
		end
	end

	////////////////////////////////////////////////////////////
	// Memory and writeback

	assign dataAddr  = exMem.result;
	assign dataWe    = exMem.ctrl.memWrite;
	// Load in writeback feeding a store right behind it
	assign dataWdata = (exMem.rt != '0 && exMem.rt == memWb.ctrl.dest) ? memWb.value
		: exMem.storeVal;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			memWb.ctrl <= '0;
		end else begin
			memWb.pc        <= exMem.pc;
			memWb.ctrl      <= exMem.ctrl;
			memWb.ctrl.tNew <= ageTime(exMem.ctrl.tNew);
			memWb.value     <= exMem.ctrl.memRead ? dataRdata : exMem.result;
		end
	end

	assign grfWe    = memWb.ctrl.regWrite;
	assign grfAddr  = memWb.ctrl.dest;
	assign grfWdata = memWb.value;
	assign wbPc     = memWb.pc;

	pcAligned: assert property (@(posedge clk) disable iff (!rstN) pcF[1:0] == 2'b00);
	storeAligned: assert property (@(posedge clk) disable iff (!rstN)
		dataWe |-> dataAddr[1:0] == 2'b00);

endmodule

//--- bench/cpuChecker.sv
`timescale 1ns/1ps
module cpuChecker import cpuPkg::*; #(
	parameter wordT resetPc   = 32'h0000_3000,
	parameter int   progWords = 200,
	parameter int   dataWords = 256
) (
	input  logic    clk,
	input  logic    rstN,
	input  logic    endRun,
	input  wordT    prog [progWords],
	input  wordT    dataInit [dataWords],
	input  logic    grfWe,
	input  regAddrT grfAddr,
	input  wordT    grfWdata,
	input  wordT    wbPc,
	input  logic    dataWe,
	input  wordT    dataAddr,
	input  wordT    dataWdata,
	output int      mismatches,
	output int      otherErrors
);

	typedef struct packed {
		regAddrT addr;
		wordT    data;
		wordT    pc;
	} regWriteT;

	typedef struct packed {
		wordT addr;
		wordT data;
	} storeT;

	localparam wordT loopPc = resetPc + wordT'(4 * (progWords - 2)); // Final self-loop

	regWriteT expWrites [$];
	storeT    expStores [$];
	regWriteT w;
	storeT    s;
	int       mismatchCount = 0;
	int       otherCount = 0;
	int       activeNegs = 0;
	logic     built = 1'b0;
	logic     endChecked = 1'b0;

	assign mismatches  = mismatchCount;
	assign otherErrors = otherCount;

	function automatic wordT progWord(wordT addr);
		wordT off;
		off = addr - resetPc;
		return (off < wordT'(progWords * 4)) ? prog[off[9:2]] : '0;
	endfunction

	task automatic checkValue(string name, wordT got, wordT exp);
		if (got !== exp) begin
			mismatchCount++;
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
		end
	endtask

	//////////////////////////////////////////////////////////////
	// Instruction-level model, one instruction per step, delay slots included

	task automatic buildExpected();
		wordT       regs [32];
		wordT       mem [dataWords];
		wordT       pc, nextPc, newNext, instr, immS, immZ, a, b, val, addr;
		logic [5:0] op;
		regAddrT    dest;
		logic       writes;
		int         steps;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		for (int i = 0; i < dataWords; i++)
			mem[i] = dataInit[i];
		pc = resetPc;
		nextPc = resetPc + 32'd4;
		steps = 0;
		while (pc != loopPc && steps < 4 * progWords) begin
			instr   = progWord(pc);
			op      = instr[31:26];
			a       = regs[instr[25:21]];
			b       = regs[instr[20:16]];
			immS    = {{16{instr[15]}}, instr[15:0]};
			immZ    = {16'h0000, instr[15:0]};
			newNext = nextPc + 32'd4;
			writes  = 1'b1;
			dest    = instr[20:16];
			val     = '0;
			case (op)
				opSpecial: begin
					dest = instr[15:11];
					case (instr[5:0])
						fnAdd:   val = a + b; // Wraps
						fnSub:   val = a - b;
						fnAnd:   val = a & b;
						fnOr:    val = a | b;
						fnSlt:   val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						fnSltu:  val = (a < b) ? 32'd1 : 32'd0;
						default: writes = 1'b0;
					endcase
				end
				opAddi: val = a + immS;
				opAndi: val = a & immZ;
				opOri:  val = a | immZ;
				opLui:  val = {instr[15:0], 16'h0000};
				opLw: begin
					addr = a + immS;
					val = mem[addr[9:2]];
				end
				opSw: begin
					writes = 1'b0;
					addr = a + immS;
					mem[addr[9:2]] = b;
					expStores.push_back(storeT'{addr: addr, data: b});
				end
				opBeq, opBne: begin
					writes = 1'b0;
					if ((a == b) == (op == opBeq))
						newNext = nextPc + (immS << 2); // Relative to the delay slot
				end
				opJal: begin
					dest = regRa;
					val = pc + 32'd8;
					newNext = {nextPc[31:28], instr[25:0], 2'b00};
				end
				default: writes = 1'b0;
			endcase
			if (writes) begin
				if (dest != '0)
					regs[dest] = val;
				expWrites.push_back(regWriteT'{addr: dest, data: val, pc: pc});
			end
			pc = nextPc;
			nextPc = newNext;
			steps++;
		end
		if (pc != loopPc) begin
			otherCount++;
			$display("reference model never reached the final loop at %h", loopPc);
		end
	endtask

	//////////////////////////////////////////////////////////////
	// Compare the writeback and store streams in program order

	always @(negedge clk) begin
		if (!rstN) begin
			activeNegs = 0;
			if (grfWe || dataWe) begin
				otherCount++;
				$display("write strobe high during reset (grfWe %b, dataWe %b)", grfWe, dataWe);
			end
		end else begin
			if (!built) begin
				buildExpected();
				built = 1'b1;
			end
			if (grfWe && activeNegs < 4) begin // Fetch to writeback is four cycles
				otherCount++;
				$display("register write at pc %h before any instruction could retire", wbPc);
			end
			if (dataWe && activeNegs < 3) begin
				otherCount++;
				$display("store to %h before any instruction could reach memory", dataAddr);
			end
			if (grfWe) begin
				if (expWrites.size() == 0) begin
					otherCount++;
					$display("unexpected register write to r%0d at pc %h", grfAddr, wbPc);
				end else begin
					w = expWrites.pop_front();
					checkValue("grfAddr", {27'd0, grfAddr}, {27'd0, w.addr});
					checkValue("grfWdata", grfWdata, w.data);
					checkValue("wbPc", wbPc, w.pc);
				end
			end
			if (dataWe) begin
				if (expStores.size() == 0) begin
					otherCount++;
					$display("unexpected store of %h to %h", dataWdata, dataAddr);
				end else begin
					s = expStores.pop_front();
					checkValue("dataAddr", dataAddr, s.addr);
					checkValue("dataWdata", dataWdata, s.data);
				end
			end
			if (endRun && !endChecked) begin
				endChecked = 1'b1;
				if (expWrites.size() != 0 || expStores.size() != 0) begin
					otherCount++;
					$display("%0d register writes and %0d stores never appeared",
						expWrites.size(), expStores.size());
				end
			end
			activeNegs++;
		end
	end

endmodule

//--- bench/cpuTb.sv
`timescale 1ns/1ps
module cpuTb import cpuPkg::*; ();

	localparam wordT resetPc       = 32'h0000_3000;
	localparam int   progWords     = 200;
	localparam int   dataWords     = 256;
	localparam int   loopIdx       = progWords - 2;
	localparam wordT loopPc        = resetPc + wordT'(4 * loopIdx);
	localparam int   timeoutCycles = progWords * 3 + 100;

	logic    clk = 1'b0;
	logic    rstN = 1'b0;
	logic    endRun = 1'b0;
	wordT    instAddr, dataAddr, dataWdata, grfWdata, wbPc;
	wordT    instData = '0;
	wordT    dataRdata = '0;
	logic    dataWe, grfWe;
	regAddrT grfAddr;
	wordT    prog [progWords];
	wordT    dataInit [dataWords];
	wordT    dmem [dataWords];
	wordT    lfsr = 32'd16; // Seed
	int      cycles = 0;
	int      tbErrors = 0;
	int      mismatches, otherErrors;

	always #50 clk = ~clk;

	cpuCore #(.resetPc(resetPc)) cpuCore_i (.clk(clk), .rstN(rstN), .instAddr(instAddr),
		.instData(instData), .dataAddr(dataAddr), .dataWdata(dataWdata), .dataWe(dataWe),
		.dataRdata(dataRdata), .grfWe(grfWe), .grfAddr(grfAddr), .grfWdata(grfWdata),
		.wbPc(wbPc));

	cpuChecker #(.resetPc(resetPc), .progWords(progWords), .dataWords(dataWords)) cpuChecker (
		.clk(clk), .rstN(rstN), .endRun(endRun), .prog(prog), .dataInit(dataInit),
		.grfWe(grfWe), .grfAddr(grfAddr), .grfWdata(grfWdata), .wbPc(wbPc), .dataWe(dataWe),
		.dataAddr(dataAddr), .dataWdata(dataWdata), .mismatches(mismatches),
		.otherErrors(otherErrors));

	//////////////////////////////////////////////////////////////
	// Random numbers and instruction encoding

	function automatic wordT lfsrStep(wordT st);
		return st[0] ? ((st >> 1) ^ 32'h8020_0003) : (st >> 1);
	endfunction

	function automatic wordT lfsrBits(int n);
		wordT r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsrStep(lfsr);
		end
		return r;
	endfunction

	function automatic regAddrT srcReg();
		wordT v;
		v = lfsrBits(3);
		return (v == 32'd7) ? regRa : regAddrT'(v); // Lets jal links get read
	endfunction

	function automatic regAddrT destReg();
		wordT v;
		v = lfsrBits(3);
		while (v == '0)
			v = lfsrBits(3);
		return (v == 32'd7) ? regRa : regAddrT'(v);
	endfunction

	function automatic wordT iType(logic [5:0] op, regAddrT rs, regAddrT rt, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic makeProgram();
		int          kind, k;
		logic        prevCtl;
		regAddrT     rs, rt, rd;
		wordT        off, tgt;
		logic [5:0]  funct;
		prevCtl = 1'b0;
		for (int i = 0; i < loopIdx; i++) begin
			kind = int'(lfsrBits(4));
			// No branch in a delay slot or with the final loop as its slot
			while (kind > 14 || (kind >= 12 && (prevCtl || i > loopIdx - 3)))
				kind = int'(lfsrBits(4));
			prevCtl = (kind >= 12);
			rs = srcReg();
			rt = srcReg();
			rd = destReg();
			off = lfsrBits(16);
			k = int'(lfsrBits(3));
			while (k > 6)
				k = int'(lfsrBits(3));
			k = k + 2;
			if (i + 1 + k > loopIdx)
				k = loopIdx - i - 1;
			tgt = resetPc + wordT'(4 * (i + 1 + k));
			case (kind)
				0, 1, 2, 3, 4, 5: begin
					funct = (kind == 0) ? fnAdd : (kind == 1) ? fnSub : (kind == 2) ? fnAnd
						: (kind == 3) ? fnOr : (kind == 4) ? fnSlt : fnSltu;
					prog[i] = {opSpecial, rs, rt, rd, 5'd0, funct};
				end
				6:  prog[i] = iType(opAddi, rs, rd, off[15:0]);
				7:  prog[i] = iType(opAndi, rs, rd, off[15:0]);
				8:  prog[i] = iType(opOri, rs, rd, off[15:0]);
				9:  prog[i] = iType(opLui, 5'd0, rd, off[15:0]);
				// A small window of words so that loads often meet earlier stores
				10: prog[i] = iType(opLw, 5'd0, rd, {10'd0, off[3:0], 2'b00});
				11: prog[i] = iType(opSw, 5'd0, rt, {10'd0, off[3:0], 2'b00});
				12: prog[i] = iType(opBeq, rs, rt, 16'(k));
				13: prog[i] = iType(opBne, rs, rt, 16'(k));
				default: prog[i] = {opJal, tgt[27:2]};
			endcase
		end
		prog[loopIdx] = iType(opBeq, 5'd0, 5'd0, 16'hffff);
		prog[loopIdx + 1] = '0;
		for (int i = 0; i < dataWords; i++)
			dataInit[i] = lfsrBits(32);
	endtask

	//////////////////////////////////////////////////////////////
	// Memories driven shortly after the edge

	always @(posedge clk) begin
		#1;
		instData  <= (instAddr - resetPc < wordT'(progWords * 4))
			? prog[instAddr[9:2] - resetPc[9:2]] : '0;
		dataRdata <= dmem[dataAddr[9:2]];
	end

	always @(negedge clk) begin
		if (!rstN)
			dmem = dataInit;
		else if (dataWe)
			dmem[dataAddr[9:2]] = dataWdata;
	end

	always @(posedge clk) begin
		if (rstN)
			cycles <= cycles + 1;
	end

	initial begin
		makeProgram();
		repeat (16) @(posedge clk);
		#1 rstN = 1'b1;
		while (wbPc !== loopPc && cycles < timeoutCycles)
			@(negedge clk);
		if (wbPc !== loopPc) begin
			tbErrors++;
			$display("timeout: program did not finish within %0d cycles", timeoutCycles);
		end else begin
			repeat (8) @(negedge clk); // Catch stray writes after the loop
		end
		@(posedge clk);
		endRun = 1'b1;
		@(negedge clk);
		@(posedge clk);
		$display("errors: %0d mismatches, %0d other", mismatches, otherErrors + tbErrors);
		if (mismatches + otherErrors + tbErrors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

//--- files.f
design/cpuPkg.sv
design/regFile.sv
design/alu.sv
design/decoder.sv
design/hazardUnit.sv
design/cpuCore.sv
bench/cpuChecker.sv
bench/cpuTb.sv

//--- run.sh
#!/bin/sh
# Builds the core and its testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cpuTb -Mdir obj_dir -o cpuSim -f files.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/cpuSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -q "tests failed" sim.log; then
	exit 1
fi
if ! grep -q "all tests passed" sim.log; then
	echo "simulation ended without a verdict"
	exit 1
fi
exit 0
